//--- list.f
+incdir+src
src/spi_bridge_pkg.sv
src/spi_frontend.sv
src/spi_shifter.sv
src/spi_cmd_fsm.sv
src/spi_regfile.sv
src/spi_bridge_top.sv
tb/spi_bridge_tb.sv

//--- run.sh
#!/bin/sh
# Builds the SPI bridge testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module spi_bridge_tb

sim_out=$(./obj_dir/Vspi_bridge_tb)
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qF '*** TEST PASSED ***'; then
    exit 0
fi
exit 1

//--- src/spi_bridge_macros.svh
// Shared sizing constants for the SPI register bridge.
// Included by the package and by every module that sizes a byte,
// an address or the register array.

`ifndef SPI_BRIDGE_MACROS_SVH
`define SPI_BRIDGE_MACROS_SVH

// Bits per SPI byte.
`define SPI_BYTE_W 8

// Number of registers behind the bridge.
`define SPI_REG_COUNT 16

// Register address width; low bits of the address byte.
`define SPI_ADDR_W 4

// Returned on SDO while the command byte is shifted in.
`define SPI_ID_BYTE 8'hA5

`endif

//--- src/spi_bridge_pkg.sv
// Types shared by the SPI register bridge.
// Holds the opcode and state enums and the packed structs that
// travel between front end, shifter, FSM and register file.
// Import with a wildcard in the module header.

`default_nettype none

`include "spi_bridge_macros.svh"

package spi_bridge_pkg;

    // Command byte values; anything else is ignored.
    typedef enum logic [`SPI_BYTE_W-1:0] {
        OP_WRITE = 8'h02,
        OP_READ  = 8'h03
    } spi_opcode_e;

    // Transaction FSM states.
    typedef enum logic [2:0] {
        S_IDLE   = 3'd0, // CS high.
        S_CMD    = 3'd1, // Command byte in flight.
        S_ADDR   = 3'd2, // Address byte in flight.
        S_WRITE  = 3'd3, // Data bytes go to registers.
        S_READ   = 3'd4, // Data bytes come from registers.
        S_IGNORE = 3'd5  // Unknown opcode, sink the rest.
    } spi_state_e;

    // Synchronized pin events, one cycle strobes.
    typedef struct packed {
        logic sck_rise;
        logic sck_fall;
        logic cs_fall;
        logic cs_rise;
        logic sdi;      // Level, same delay as the strobes.
    } spi_edges_t;

    // Received byte.
    typedef struct packed {
        logic [`SPI_BYTE_W-1:0] data;
        logic                   valid; // One cycle strobe.
    } spi_rx_t;

    // Register file access.
    typedef struct packed {
        logic                   wr_en;
        logic                   rd_en;
        logic [`SPI_ADDR_W-1:0] addr;
        logic [`SPI_BYTE_W-1:0] wdata;
    } reg_req_t;

endpackage

`default_nettype wire

//--- src/spi_bridge_top.sv
// Top level of the SPI mode 0 register bridge.
// Pins are sampled in the system clock; SCK must be at most 1/8 of it.
// Front end, shifter, FSM and register file form a chain, and ctrl_o is register 0.

`timescale 1ns/10ps
`default_nettype none

`include "spi_bridge_macros.svh"

module spi_bridge_top
    import spi_bridge_pkg::*;
(
    input  wire logic                   spi_cs_ni,  // System clock.
    input  wire logic                   spi_sck_i,  // Async reset, active high.
    input  wire logic                   cs_n_i,     // SPI chip select, active low.
    input  wire logic                   sclk_i,     // SPI clock.
    input  wire logic                   sdi_i,      // Controller to target.
    output logic                        sdo_o,      // Target to controller.
    output logic [`SPI_BYTE_W-1:0]      ctrl_o,     // Mirror of register 0.
    output logic                        busy_o      // Transaction in progress.
);

    spi_edges_t             edges;
    spi_rx_t                rx;
    reg_req_t               req;
    logic [`SPI_BYTE_W-1:0] tx_byte;
    logic [`SPI_BYTE_W-1:0] rdata;

    spi_frontend u_frontend (
        .spi_cs_ni (spi_cs_ni),
        .spi_sck_i (spi_sck_i),
        .cs_n_i    (cs_n_i),
        .sclk_i    (sclk_i),
        .sdi_i     (sdi_i),
        .edges_o   (edges)
    );

    spi_shifter u_shifter (
        .spi_cs_ni (spi_cs_ni),
        .spi_sck_i (spi_sck_i),
        .edges_i   (edges),
        .tx_byte_i (tx_byte),
        .rx_o      (rx),
        .sdo_o     (sdo_o)
    );

    spi_cmd_fsm u_cmd_fsm (
        .spi_cs_ni (spi_cs_ni),
        .spi_sck_i (spi_sck_i),
        .edges_i   (edges),
        .rx_i      (rx),
        .rdata_i   (rdata),
        .req_o     (req),
        .tx_byte_o (tx_byte),
        .busy_o    (busy_o)
    );

    spi_regfile u_regfile (
        .spi_cs_ni (spi_cs_ni),
        .spi_sck_i (spi_sck_i),
        .req_i     (req),
        .rdata_o   (rdata),
        .ctrl_o    (ctrl_o)
    );

endmodule

`default_nettype wire

//--- src/spi_cmd_fsm.sv
// Transaction FSM for the SPI register bridge.
// Decodes the command and address bytes, then turns each data byte
// into a register write or read with auto-increment and wrap.
// Read data is prefetched so the next transmit byte is ready one
// cycle after every rx strobe.

`timescale 1ns/10ps
`default_nettype none

`include "spi_bridge_macros.svh"

module spi_cmd_fsm
    import spi_bridge_pkg::*;
(
    input  wire logic                   spi_cs_ni,  // System clock.
    input  wire logic                   spi_sck_i,  // Async reset, active high.
    input  wire spi_edges_t             edges_i,    // Only the CS strobes matter here.
    input  wire spi_rx_t                rx_i,
    input  wire logic [`SPI_BYTE_W-1:0] rdata_i,    // Valid the cycle after rd_en.
    output reg_req_t                    req_o,
    output logic [`SPI_BYTE_W-1:0]      tx_byte_o,
    output logic                        busy_o
);

    spi_state_e             state_q;
    spi_opcode_e            op_q;      // Accepted opcode.
    logic [`SPI_ADDR_W-1:0] addr_q;    // Write target, or next read to prefetch.
    logic [`SPI_BYTE_W-1:0] tx_q;      // ID byte or zero fill.
    logic                   wr_pend_q; // Write strobe, cycle after rx.
    logic [`SPI_BYTE_W-1:0] wdata_q;
    logic                   rd_now;
    logic [`SPI_ADDR_W-1:0] rd_addr;

    // Reads go out in the rx cycle itself; rdata lands in time for the shifter.
    assign rd_now = rx_i.valid &&
                    ((state_q == S_ADDR && op_q == OP_READ) || state_q == S_READ);
    assign rd_addr = (state_q == S_ADDR) ? rx_i.data[`SPI_ADDR_W-1:0] : addr_q;

    assign req_o = '{
        wr_en: wr_pend_q,
        rd_en: rd_now,
        addr:  rd_now ? rd_addr : addr_q,
        wdata: wdata_q
    };

    // Register data while reading; ID or zeros otherwise.
    assign tx_byte_o = (state_q == S_READ) ? rdata_i : tx_q;
    assign busy_o    = (state_q != S_IDLE);

    always_ff @(posedge spi_cs_ni or posedge spi_sck_i) begin
        if (spi_sck_i) begin
            state_q   <= S_IDLE;
            op_q      <= OP_WRITE;
            addr_q    <= '0;
            tx_q      <= `SPI_ID_BYTE; // Ready for the first CS fall.
            wr_pend_q <= 1'b0;
        end else begin
            wr_pend_q <= 1'b0;
            if (edges_i.cs_rise) begin
                state_q <= S_IDLE; // Ends the transaction, even mid-byte.
                tx_q    <= `SPI_ID_BYTE;
            end else begin
                if (wr_pend_q) begin
                    addr_q <= addr_q + 1'b1; // Wraps 15 -> 0.
                end
                case (state_q)
                    S_IDLE: begin
                        if (edges_i.cs_fall) state_q <= S_CMD;
                    end
                    S_CMD: begin
                        if (rx_i.valid) begin
                            tx_q <= '0; // Address phase sends zeros.
                            case (spi_opcode_e'(rx_i.data))
                                OP_WRITE, OP_READ: begin
                                    op_q    <= spi_opcode_e'(rx_i.data);
                                    state_q <= S_ADDR;
                                end
                                default: state_q <= S_IGNORE;
                            endcase
                        end
                    end
                    S_ADDR: begin
                        if (rx_i.valid && op_q == OP_READ) begin
                            state_q <= S_READ;
                            addr_q  <= rx_i.data[`SPI_ADDR_W-1:0] + 1'b1; // Next prefetch.
                        end else if (rx_i.valid) begin
                            state_q <= S_WRITE;
                            addr_q  <= rx_i.data[`SPI_ADDR_W-1:0];
                        end
                    end
                    S_WRITE: begin
                        if (rx_i.valid) wr_pend_q <= 1'b1;
                    end
                    S_READ: begin
                        if (rx_i.valid) addr_q <= addr_q + 1'b1; // Prefetch issued now.
                    end
                    S_IGNORE: begin
                        // Sink bytes until CS rises.
                    end
                    default: state_q <= S_IDLE;
                endcase
            end
        end
    end

    // Data byte held for the write strobe.
    always_ff @(posedge spi_cs_ni) begin
        if (rx_i.valid) wdata_q <= rx_i.data;
    end

    // Bytes only arrive inside a transaction.
    a_rx_in_txn : assert property (
        @(posedge spi_cs_ni) disable iff (spi_sck_i)
        rx_i.valid |-> (state_q != S_IDLE)
    );

endmodule

`default_nettype wire

//--- src/spi_frontend.sv
// SPI pin front end.
// Brings CS, SCK and SDI into the system clock through two flop
// synchronizers and turns level changes into one cycle strobes.
// A pin change shows up as a strobe three cycles later.

`timescale 1ns/10ps
`default_nettype none

module spi_frontend
    import spi_bridge_pkg::*;
(
    input  wire logic spi_cs_ni,  // System clock.
    input  wire logic spi_sck_i,  // Async reset, active high.
    input  wire logic cs_n_i,     // SPI chip select, active low.
    input  wire logic sclk_i,     // SPI clock.
    input  wire logic sdi_i,      // SPI data in.
    output spi_edges_t edges_o
);

    // Bit positions inside the pin vectors.
    localparam int PIN_CS  = 2;
    localparam int PIN_SCK = 1;
    localparam int PIN_SDI = 0;

    // Idle bus has CS high and SCK low in mode 0.
    localparam logic [2:0] PIN_IDLE = 3'b100;

    logic [2:0] meta_q;  // First sync stage.
    logic [2:0] sync_q;  // Second sync stage.
    logic [2:0] prev_q;  // Last cycle's synchronized pins.

    always_ff @(posedge spi_cs_ni or posedge spi_sck_i) begin
        if (spi_sck_i) begin
            meta_q  <= PIN_IDLE; // Idle levels, so no strobe fires out of reset.
            sync_q  <= PIN_IDLE;
            prev_q  <= PIN_IDLE;
            edges_o <= '0;
        end else begin
            meta_q <= {cs_n_i, sclk_i, sdi_i};
            sync_q <= meta_q;
            prev_q <= sync_q;

            // Registered edge detect.
            edges_o.sck_rise <= sync_q[PIN_SCK] & ~prev_q[PIN_SCK];
            edges_o.sck_fall <= ~sync_q[PIN_SCK] & prev_q[PIN_SCK];
            edges_o.cs_fall  <= ~sync_q[PIN_CS] & prev_q[PIN_CS];
            edges_o.cs_rise  <= sync_q[PIN_CS] & ~prev_q[PIN_CS];
            edges_o.sdi      <= sync_q[PIN_SDI]; // Aligned with sck_rise.
        end
    end

    // SCK levels last four samples or more, which keeps SCK at 1/8 of the clock or slower.
    a_sck_rate : assert property (
        @(posedge spi_cs_ni) disable iff (spi_sck_i)
        (edges_o.sck_rise || edges_o.sck_fall) |->
            !($past(edges_o.sck_rise || edges_o.sck_fall, 1) ||
              $past(edges_o.sck_rise || edges_o.sck_fall, 2) ||
              $past(edges_o.sck_rise || edges_o.sck_fall, 3))
    );

endmodule

`default_nettype wire

//--- src/spi_regfile.sv
// Register file behind the SPI bridge.
// Sixteen 8-bit registers, cleared by reset, with a synchronous
// write and a registered read. Register 0 drives ctrl_o.

`timescale 1ns/10ps
`default_nettype none

`include "spi_bridge_macros.svh"

module spi_regfile
    import spi_bridge_pkg::*;
(
    input  wire logic                   spi_cs_ni,  // System clock.
    input  wire logic                   spi_sck_i,  // Async reset, active high.
    input  wire reg_req_t               req_i,
    output logic [`SPI_BYTE_W-1:0]      rdata_o,    // Valid the cycle after rd_en.
    output logic [`SPI_BYTE_W-1:0]      ctrl_o
);

    logic [`SPI_BYTE_W-1:0] regs_q [`SPI_REG_COUNT];

    always_ff @(posedge spi_cs_ni or posedge spi_sck_i) begin
        if (spi_sck_i) begin
            for (int i = 0; i < `SPI_REG_COUNT; i++) begin
                regs_q[i] <= '0; // All registers read 0 after reset.
            end
        end else if (req_i.wr_en) begin
            regs_q[req_i.addr] <= req_i.wdata;
        end
    end

    // Read port holds its value between reads.
    always_ff @(posedge spi_cs_ni) begin
        if (req_i.rd_en) rdata_o <= regs_q[req_i.addr];
    end

    assign ctrl_o = regs_q[0];

endmodule

`default_nettype wire

//--- src/spi_shifter.sv
// SPI mode 0 shift core.
// Samples SDI on each SCK rise into a byte and strobes rx_o.valid
// once eight bits are in. SDO is shifted MSB first on each SCK fall.
// The transmit byte is taken at CS fall and on the cycle after each
// rx_o.valid strobe, then moved out at the next byte boundary.

`timescale 1ns/10ps
`default_nettype none

`include "spi_bridge_macros.svh"

module spi_shifter
    import spi_bridge_pkg::*;
(
    input  wire logic                   spi_cs_ni,  // System clock.
    input  wire logic                   spi_sck_i,  // Async reset, active high.
    input  wire spi_edges_t             edges_i,
    input  wire logic [`SPI_BYTE_W-1:0] tx_byte_i,  // Next byte to send.
    output spi_rx_t                     rx_o,
    output logic                        sdo_o
);

    localparam int CNT_W = $clog2(`SPI_BYTE_W);
    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(`SPI_BYTE_W - 1);

    logic                   cs_active; // Between CS fall and CS rise.
    logic [CNT_W-1:0]       bit_cnt;   // Bits received in this byte.
    logic                   rx_valid;
    logic                   ld_next;   // Cycle after rx_valid.
    logic [`SPI_BYTE_W-1:0] rx_sr;     // Receive shifter.
    logic [`SPI_BYTE_W-1:0] tx_sr;     // Transmit shifter, MSB on SDO.
    logic [`SPI_BYTE_W-1:0] tx_next;   // Byte waiting for the boundary.

    always_ff @(posedge spi_cs_ni or posedge spi_sck_i) begin
        if (spi_sck_i) begin
            cs_active <= 1'b0;
            bit_cnt   <= '0;
            rx_valid  <= 1'b0;
            ld_next   <= 1'b0;
            tx_sr     <= '0; // SDO low out of reset.
        end else begin
            rx_valid <= 1'b0;
            ld_next  <= rx_valid;
            if (edges_i.cs_fall) begin
                // New transfer puts the first byte on SDO before the first SCK rise.
                cs_active <= 1'b1;
                bit_cnt   <= '0;
                tx_sr     <= tx_byte_i;
            end else if (edges_i.cs_rise) begin
                cs_active <= 1'b0;
                bit_cnt   <= '0; // Partial byte is dropped.
            end else if (cs_active) begin
                if (edges_i.sck_rise) begin
                    bit_cnt  <= bit_cnt + 1'b1;          // Wraps after the 8th bit.
                    rx_valid <= (bit_cnt == LAST_BIT);
                end
                if (edges_i.sck_fall) begin
                    if (bit_cnt == '0) begin
                        tx_sr <= tx_next;                // Byte boundary.
                    end else begin
                        tx_sr <= {tx_sr[`SPI_BYTE_W-2:0], 1'b0};
                    end
                end
            end
        end
    end

    // Receive shifter and the waiting transmit byte.
    always_ff @(posedge spi_cs_ni) begin
        if (cs_active && edges_i.sck_rise) begin
            rx_sr <= {rx_sr[`SPI_BYTE_W-2:0], edges_i.sdi}; // MSB first.
        end
        if (ld_next) begin
            tx_next <= tx_byte_i; // FSM has answered the last byte by now.
        end
    end

    assign rx_o  = '{data: rx_sr, valid: rx_valid}; // Holds until the next SCK rise.
    assign sdo_o = tx_sr[`SPI_BYTE_W-1];

    // SCK only toggles inside a CS window.
    a_sck_in_cs : assert property (
        @(posedge spi_cs_ni) disable iff (spi_sck_i)
        (edges_i.sck_rise || edges_i.sck_fall) |-> cs_active
    );

endmodule

`default_nettype wire

//--- tb/spi_bridge_tb.sv
// Self-checking testbench for the SPI register bridge.
// A bit-level SPI mode 0 controller runs a table of transactions.
// A 16-entry register model predicts SDO data and ctrl_o.
// Compile with the file list in the project root; top is spi_bridge_tb.

`timescale 1ns/10ps
`default_nettype none

`include "spi_bridge_macros.svh"

module spi_bridge_tb;

    localparam int         MAX_BYTES = `SPI_REG_COUNT; // Longest data burst.
    localparam int         HALF_SCK  = 4;              // System cycles per SCK level.
    localparam logic [7:0] ID_BYTE   = 8'hA5;
    localparam logic [7:0] CMD_WRITE = 8'h02;
    localparam logic [7:0] CMD_READ  = 8'h03;

    // One transaction of the test table.
    typedef struct packed {
        logic [7:0]                op;
        logic [7:0]                addr;     // Only the low 4 bits select.
        logic [4:0]                nbytes;   // Full data bytes.
        logic [3:0]                cut_bits; // Bits of a trailing partial byte.
        logic [MAX_BYTES-1:0][7:0] data;     // data[0] goes first.
    } row_t;

    logic       clk;
    logic       rst;
    logic       cs_n;
    logic       sclk;
    logic       sdi;
    logic       sdo;
    logic [7:0] ctrl;
    logic       busy;

    row_t       rows[$];
    logic [7:0] model[`SPI_REG_COUNT]; // Expected register contents.
    int         total_bytes  = 0;      // Every SPI byte, partial ones too.
    int         limit_cycles = 2000;
    int         cycles       = 0;
    int         errors       = 0;
    int         checks       = 0;
    int         cur_row      = -1;
    integer     seed         = 32'h4e05_c627;

    spi_bridge_top dut0 (
        .spi_cs_ni (clk),
        .spi_sck_i (rst),
        .cs_n_i    (cs_n),
        .sclk_i    (sclk),
        .sdi_i     (sdi),
        .sdo_o     (sdo),
        .ctrl_o    (ctrl),
        .busy_o    (busy)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk; // 4 ns period.
    end

    // Watchdog.
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit_cycles) begin
            $display("Timeout: no end of test after %0d cycles", limit_cycles);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    task automatic check_val(input string name, input logic [7:0] exp, input logic [7:0] got);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Fail %s (row %0d): expected %02h, got %02h", name, cur_row, exp, got);
        end
    endtask

    task automatic add_row(input logic [7:0] op, input logic [7:0] addr, input int n,
                           input int cut, input logic [63:0] bytes);
        row_t r;
        r          = '0;
        r.op       = op;
        r.addr     = addr;
        r.nbytes   = n[4:0];
        r.cut_bits = cut[3:0];
        for (int i = 0; i < 8; i++) begin
            r.data[i] = bytes[63-8*i -: 8]; // Leftmost literal byte first.
        end
        rows.push_back(r);
        total_bytes += 2 + n + ((cut != 0) ? 1 : 0);
    endtask

    // Mode 0 sets SDI while SCK is low and takes SDO at the rising edge.
    task automatic shift_bits(input logic [7:0] tx, input int nbits, output logic [7:0] rx);
        rx = '0;
        for (int b = 0; b < nbits; b++) begin
            sdi = tx[7-b]; // MSB first.
            repeat (HALF_SCK) @(negedge clk);
            sclk = 1'b1;
            rx   = {rx[6:0], sdo};
            repeat (HALF_SCK) @(negedge clk);
            sclk = 1'b0;
        end
    endtask

    task automatic run_row(input row_t r);
        logic [7:0] got;
        logic [7:0] exp;
        logic [3:0] a;
        logic       is_wr;
        logic       is_rd;
        is_wr = (r.op == CMD_WRITE);
        is_rd = (r.op == CMD_READ);
        @(negedge clk);
        cs_n = 1'b0;
        repeat (HALF_SCK) @(negedge clk); // First SDO bit settles.
        shift_bits(r.op, 8, got);
        check_val("sdo_o cmd", ID_BYTE, got);
        check_val("busy_o", 8'h01, {7'd0, busy});
        shift_bits(r.addr, 8, got);
        check_val("sdo_o addr", 8'h00, got);
        for (int i = 0; i < int'(r.nbytes); i++) begin
            a = r.addr[3:0] + 4'(i); // Wraps 15 to 0.
            shift_bits(r.data[i], 8, got);
            exp = is_rd ? model[a] : 8'h00; // Writes and unknown ops send zeros.
            check_val("sdo_o data", exp, got);
            if (is_wr) begin
                model[a] = r.data[i];
            end
        end
        if (r.cut_bits != 0) begin
            shift_bits(r.data[r.nbytes], int'(r.cut_bits), got); // Target drops it.
        end
        repeat (HALF_SCK) @(negedge clk);
        cs_n = 1'b1;
        repeat (2 * HALF_SCK) @(negedge clk);
        check_val("busy_o", 8'h00, {7'd0, busy});
        check_val("ctrl_o", model[0], ctrl);
    endtask

    initial begin : main
        logic [31:0] rnd;
        int          rn;
        rst  = 1'b1;
        cs_n = 1'b1;
        sclk = 1'b0;
        sdi  = 1'b0;
        for (int i = 0; i < `SPI_REG_COUNT; i++) begin
            model[i] = 8'h00; // Reset value.
        end

        add_row(CMD_READ,  8'h03, 2, 0, 64'h0);                  // Unwritten reads 0.
        add_row(CMD_WRITE, 8'hA3, 1, 0, 64'h5A00_0000_0000_0000); // Upper address bits ignored.
        add_row(CMD_READ,  8'h03, 1, 0, 64'h0);
        add_row(CMD_WRITE, 8'h0E, 4, 0, 64'h1122_3344_0000_0000); // 14, 15, 0, 1.
        add_row(CMD_READ,  8'h0E, 4, 0, 64'h0);
        add_row(CMD_WRITE, 8'h00, 1, 0, 64'h3C00_0000_0000_0000);
        add_row(CMD_WRITE, 8'h00, 1, 0, 64'h9600_0000_0000_0000); // ctrl_o follows.
        add_row(8'h05,     8'h03, 3, 0, 64'hFFFF_FF00_0000_0000); // Unknown opcode.
        add_row(8'hFF,     8'h00, 2, 0, 64'hAA55_0000_0000_0000);
        add_row(CMD_READ,  8'h00, 8, 0, 64'h0);                  // Nothing changed.
        add_row(CMD_WRITE, 8'h05, 1, 3, 64'hA15B_0000_0000_0000); // Partial byte after A1.
        add_row(CMD_WRITE, 8'h08, 0, 3, 64'hE700_0000_0000_0000); // Only a partial byte.
        add_row(CMD_READ,  8'h05, 4, 0, 64'h0);
        add_row(CMD_READ,  8'h02, 1, 5, 64'h0);                  // Read cut short.

        // Random write and read back pairs.
        for (int k = 0; k < 3; k++) begin
            rnd = $random(seed);
            rn  = 1 + int'(rnd[5:4]);
            add_row(CMD_WRITE, rnd[15:8], rn, 0, {$random(seed), $random(seed)});
            add_row(CMD_READ, {4'h0, rnd[11:8]}, rn, 0, 64'h0);
        end
        add_row(CMD_READ, 8'h00, 16, 0, 64'h0); // Full sweep.
        limit_cycles = total_bytes * 80 + 2000;

        repeat (16) @(negedge clk);
        rst = 1'b0;
        repeat (4) @(negedge clk);
        check_val("busy_o", 8'h00, {7'd0, busy});
        check_val("sdo_o", 8'h00, {7'd0, sdo});
        check_val("ctrl_o", 8'h00, ctrl);

        foreach (rows[k]) begin
            cur_row = k;
            run_row(rows[k]);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
